/* logic/rv_isa_pkg.sv */
package rv_isa_pkg;

    ////////////////////
    // Widths

    localparam int xlen      = 32;
    localparam int reg_idx_w = 5;

    typedef logic [xlen-1:0]      word_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;

    ////////////////////
    // Major opcodes kept by the core

    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,  // R-type ALU
        op_imm    = 7'b0010011,  // I-type ALU
        op_branch = 7'b1100011   // Conditional branches
    } opcode_e;

    // ALU funct3 codes, shared by R-type and I-type
    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_or  = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;

    localparam logic [6:0] f7_sub = 7'b0100000;  // SUB when funct3 is add

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt
    } alu_op_e;

    // Values match the branch funct3 field
    typedef enum logic [2:0] {
        br_eq = 3'b000,
        br_ne = 3'b001,
        br_lt = 3'b100,
        br_ge = 3'b101
    } branch_e;

    typedef enum logic [1:0] {
        fwd_none = 2'd0,  // Register file value
        fwd_wb   = 2'd1,
        fwd_mem  = 2'd2
    } fwd_sel_e;

endpackage

/* logic/rv_pipe_pkg.sv */
package rv_pipe_pkg;

    import rv_isa_pkg::*;

    // Decoded control for one instruction
    typedef struct packed {
        logic    reg_write;
        logic    alu_src_imm;   // Operand B from the immediate
        logic    is_branch;
        alu_op_e alu_op;
        branch_e br_op;
    } ctrl_t;

    // All zero is a bubble, nothing written and no branch
    localparam ctrl_t ctrl_nop = '0;

    ////////////////////
    // Stage registers

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    pc;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    rs1_data;
        word_t    rs2_data;
        word_t    imm;
    } id_ex_t;

    // Also used between memory slot and writeback
    typedef struct packed {
        logic     reg_write;
        reg_idx_t rd;
        word_t    result;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

endpackage

/* logic/rv_decoder.sv */
`timescale 1ns/10ps

module rv_decoder
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  word_t    instr,
    output ctrl_t    ctrl,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output reg_idx_t rd,
    output word_t    imm
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_b;
    alu_op_e    f3_op;
    logic       f3_ok;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

    // funct3 to ALU operation, same table for register and immediate forms
    always_comb
    begin
        f3_ok = 1'b1;
        case (funct3)
            f3_add:  f3_op = alu_add;
            f3_slt:  f3_op = alu_slt;
            f3_xor:  f3_op = alu_xor;
            f3_or:   f3_op = alu_or;
            f3_and:  f3_op = alu_and;
            default:
            begin
                f3_op = alu_add;
                f3_ok = 1'b0;   // Shifts and unsigned compares not kept
            end
        endcase
    end

    always_comb
    begin
        ctrl = ctrl_nop;
        imm  = imm_i;
        case (opcode)
            op_reg:
            begin
                ctrl.reg_write = f3_ok;
                ctrl.alu_op    = (funct3 == f3_add && funct7 == f7_sub) ? alu_sub : f3_op;
            end
            op_imm:
            begin
                ctrl.reg_write   = f3_ok;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = f3_op;
            end
            op_branch:
            begin
                if (funct3 inside {br_eq, br_ne, br_lt, br_ge})
                begin
                    ctrl.is_branch = 1'b1;
                    ctrl.br_op     = branch_e'(funct3);
                    imm            = imm_b;   // Offset from the branch pc
                end
            end
            default: ;  // Unknown opcode stays a bubble
        endcase
    end

endmodule

/* logic/rv_regfile.sv */
`timescale 1ns/10ps

module rv_regfile
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
#(
    parameter int reg_count = 32
)(
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  wb_t      wb
);

    word_t regs [reg_count];
    logic  wr_en;

    // x0 and indices past the file are never written
    assign wr_en = wb.valid && wb.rd != '0 && wb.rd < reg_count;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < reg_count; i++)
                regs[i] <= '0;
        end
        else if (wr_en)
            regs[wb.rd] <= wb.data;
    end

    // Same-cycle write passes straight through
    function automatic word_t read_port(input reg_idx_t idx);
        if (idx == '0 || idx >= reg_count)
            return '0;
        if (wr_en && idx == wb.rd)
            return wb.data;
        return regs[idx];
    endfunction

    always_comb
    begin
        rs1_data = read_port(rs1);
        rs2_data = read_port(rs2);
    end

endmodule

/* logic/rv_alu.sv */
`timescale 1ns/10ps

module rv_alu
    import rv_isa_pkg::*;
(
    input  word_t   op_a,
    input  word_t   op_b,
    input  alu_op_e alu_op,
    input  branch_e br_op,
    input  logic    is_branch,
    output word_t   result,
    output logic    branch_taken
);

    logic a_eq_b;
    logic a_lt_b;
    logic cond;

    assign a_eq_b = (op_a == op_b);
    assign a_lt_b = ($signed(op_a) < $signed(op_b));  // Signed for SLT and BLT/BGE

    ////////////////////
    // Arithmetic and logic

    always_comb
    begin
        case (alu_op)
            alu_add: result = op_a + op_b;
            alu_sub: result = op_a - op_b;
            alu_and: result = op_a & op_b;
            alu_or:  result = op_a | op_b;
            alu_xor: result = op_a ^ op_b;
            alu_slt: result = {{(xlen-1){1'b0}}, a_lt_b};
            default: result = op_a + op_b;
        endcase
    end

    ////////////////////
    // Branch condition

    always_comb
    begin
        case (br_op)
            br_eq:   cond = a_eq_b;
            br_ne:   cond = !a_eq_b;
            br_lt:   cond = a_lt_b;
            br_ge:   cond = !a_lt_b;
            default: cond = 1'b0;
        endcase
    end

    assign branch_taken = is_branch && cond;

endmodule

/* logic/rv_hazard.sv */
`timescale 1ns/10ps

module rv_hazard
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  reg_idx_t ex_rs1,
    input  reg_idx_t ex_rs2,
    input  ex_mem_t  mem_stage,
    input  ex_mem_t  wb_stage,
    input  logic     branch_taken,
    output fwd_sel_e fwd_a,
    output fwd_sel_e fwd_b,
    output logic     flush
);

    // Newest producer wins, x0 is never forwarded
    function automatic fwd_sel_e pick(input reg_idx_t rs, input ex_mem_t mem_s,
                                      input ex_mem_t wb_s);
        if (rs == '0)
            return fwd_none;
        if (mem_s.reg_write && mem_s.rd == rs)
            return fwd_mem;
        if (wb_s.reg_write && wb_s.rd == rs)
            return fwd_wb;
        return fwd_none;
    endfunction

    assign fwd_a = pick(ex_rs1, mem_stage, wb_stage);
    assign fwd_b = pick(ex_rs2, mem_stage, wb_stage);

    assign flush = branch_taken;  // Kills decode and execute on a taken branch

endmodule

/* logic/rv_core.sv */
`timescale 1ns/10ps

module rv_core
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
#(
    parameter word_t reset_pc  = 32'h0000_0000,
    parameter int    reg_count = 32
)(
    input  logic  clk,
    input  logic  rst,
    output word_t instr_addr,
    input  word_t instr_data,
    output wb_t   wb
);

    typedef struct packed {
        word_t instr;
        word_t pc;
    } if_id_t;

    word_t    pc;
    if_id_t   if_id;
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    ex_mem_t  mem_wb;

    ctrl_t    dec_ctrl;
    reg_idx_t dec_rs1;
    reg_idx_t dec_rs2;
    reg_idx_t dec_rd;
    word_t    dec_imm;
    word_t    rs1_data;
    word_t    rs2_data;

    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
    logic     flush;
    logic     branch_taken;
    word_t    src_a;
    word_t    src_b;
    word_t    alu_b;
    word_t    alu_result;
    word_t    branch_target;

    function automatic word_t fwd_pick(input fwd_sel_e sel, input word_t reg_val,
                                       input word_t mem_val, input word_t wb_val);
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    ////////////////////
    // Decode

    rv_decoder u_decoder (
        .instr (if_id.instr),
        .ctrl  (dec_ctrl),
        .rs1   (dec_rs1),
        .rs2   (dec_rs2),
        .rd    (dec_rd),
        .imm   (dec_imm)
    );

    rv_regfile #(
        .reg_count (reg_count)
    ) u_regfile (
        .clk      (clk),
        .rst      (rst),
        .rs1      (dec_rs1),
        .rs2      (dec_rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

    ////////////////////
    // Execute

    assign src_a         = fwd_pick(fwd_a, id_ex.rs1_data, ex_mem.result, mem_wb.result);
    assign src_b         = fwd_pick(fwd_b, id_ex.rs2_data, ex_mem.result, mem_wb.result);
    assign alu_b         = id_ex.ctrl.alu_src_imm ? id_ex.imm : src_b;
    assign branch_target = id_ex.pc + id_ex.imm;

    rv_alu u_alu (
        .op_a         (src_a),
        .op_b         (alu_b),
        .alu_op       (id_ex.ctrl.alu_op),
        .br_op        (id_ex.ctrl.br_op),
        .is_branch    (id_ex.ctrl.is_branch),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    rv_hazard u_hazard (
        .ex_rs1       (id_ex.rs1),
        .ex_rs2       (id_ex.rs2),
        .mem_stage    (ex_mem),
        .wb_stage     (mem_wb),
        .branch_taken (branch_taken),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b),
        .flush        (flush)
    );

    ////////////////////
    // PC and stage registers

    assign instr_addr = pc;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            pc     <= reset_pc;
            if_id  <= '0;       // Zero word decodes as a bubble
            id_ex  <= '0;
            ex_mem <= '0;
            mem_wb <= '0;
        end
        else
        begin
            pc <= branch_taken ? branch_target : pc + 32'd4;
            if (flush)
            begin
                if_id <= '0;    // Drop the two younger instructions
                id_ex <= '0;
            end
            else
            begin
                if_id <= '{instr: instr_data, pc: pc};
                id_ex <= '{ctrl: dec_ctrl, pc: if_id.pc, rs1: dec_rs1, rs2: dec_rs2,
                           rd: dec_rd, rs1_data: rs1_data, rs2_data: rs2_data,
                           imm: dec_imm};
            end
            ex_mem <= '{reg_write: id_ex.ctrl.reg_write, rd: id_ex.rd, result: alu_result};
            mem_wb <= ex_mem;   // Memory slot only passes the result on
        end
    end

    // Retiring write, committed by the register file at the next edge
    assign wb = '{valid: mem_wb.reg_write, rd: mem_wb.rd, data: mem_wb.result};

endmodule

/* bench/rv_core_tb.sv */
`timescale 1ns/10ps

module rv_core_tb
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
();

    localparam word_t reset_pc = 32'h0000_0000;
    localparam int    timeout  = 20;   // Cycles per wait

    // funct3 codes from the RV32I encoding
    localparam logic [2:0] fn_add = 3'b000;
    localparam logic [2:0] fn_slt = 3'b010;
    localparam logic [2:0] fn_xor = 3'b100;
    localparam logic [2:0] fn_or  = 3'b110;
    localparam logic [2:0] fn_and = 3'b111;
    localparam logic [2:0] fn_beq = 3'b000;
    localparam logic [2:0] fn_bne = 3'b001;
    localparam logic [2:0] fn_blt = 3'b100;
    localparam logic [2:0] fn_bge = 3'b101;

    logic     clk;
    logic     rst;
    word_t    instr_addr;
    word_t    instr_data;
    wb_t      wb;

    word_t    prog [64];
    int       prog_len;
    string    exp_name [$];
    reg_idx_t exp_rd [$];
    word_t    exp_data [$];
    int       mismatches;
    int       timeouts;

    rv_core #(
        .reset_pc  (reset_pc),
        .reg_count (32)
    ) DUT (
        .clk        (clk),
        .rst        (rst),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .wb         (wb)
    );

    assign instr_data = prog[instr_addr[7:2]];  // Same-cycle instruction memory

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////
    // Instruction encoding

    function automatic word_t reg_op(input logic [6:0] f7, input logic [2:0] f3,
                                     input reg_idx_t rd, input reg_idx_t rs1,
                                     input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t imm_op(input logic [2:0] f3, input reg_idx_t rd,
                                     input reg_idx_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    // Byte offset from the branch itself
    function automatic word_t branch_to(input logic [2:0] f3, input reg_idx_t rs1,
                                        input reg_idx_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    task automatic emit(input word_t instr);
        prog[prog_len] = instr;
        prog_len++;
    endtask

    // Instruction plus the writeback it must produce
    task automatic retire(input string name, input word_t instr, input reg_idx_t rd,
                          input word_t data);
        emit(instr);
        exp_name.push_back(name);
        exp_rd.push_back(rd);
        exp_data.push_back(data);
    endtask

    ////////////////////
    // Program and expected writebacks

    task automatic write_program();
        prog_len = 0;
        for (int i = 0; i < 64; i++)
            prog[i] = '0;   // Zero word is a bubble
        retire("addi", imm_op(fn_add, 5'd1, 5'd0, 12'h005), 5'd1, 32'h0000_0005);
        retire("ori", imm_op(fn_or, 5'd2, 5'd0, 12'h0F0), 5'd2, 32'h0000_00F0);
        retire("xori", imm_op(fn_xor, 5'd3, 5'd0, 12'h055), 5'd3, 32'h0000_0055);
        retire("andi", imm_op(fn_and, 5'd4, 5'd2, 12'h030), 5'd4, 32'h0000_0030);
        retire("addi_neg", imm_op(fn_add, 5'd6, 5'd0, 12'hFF9), 5'd6, 32'hFFFF_FFF9);
        retire("slti", imm_op(fn_slt, 5'd5, 5'd6, 12'hFFD), 5'd5, 32'h0000_0001); // -7 < -3
        retire("add", reg_op(7'h00, fn_add, 5'd7, 5'd1, 5'd2), 5'd7, 32'h0000_00F5);
        retire("sub", reg_op(7'h20, fn_add, 5'd8, 5'd1, 5'd2), 5'd8, 32'hFFFF_FF15);
        retire("and", reg_op(7'h00, fn_and, 5'd9, 5'd2, 5'd3), 5'd9, 32'h0000_0050);
        retire("or", reg_op(7'h00, fn_or, 5'd10, 5'd2, 5'd3), 5'd10, 32'h0000_00F5);
        retire("xor", reg_op(7'h00, fn_xor, 5'd11, 5'd2, 5'd3), 5'd11, 32'h0000_00A5);
        retire("slt_true", reg_op(7'h00, fn_slt, 5'd12, 5'd6, 5'd1), 5'd12, 32'h1);
        retire("slt_false", reg_op(7'h00, fn_slt, 5'd13, 5'd1, 5'd6), 5'd13, 32'h0);
        // Back-to-back chain on x14
        retire("chain_0", imm_op(fn_add, 5'd14, 5'd0, 12'h001), 5'd14, 32'h1);
        retire("chain_1", reg_op(7'h00, fn_add, 5'd14, 5'd14, 5'd14), 5'd14, 32'h2);
        retire("chain_2", reg_op(7'h00, fn_add, 5'd14, 5'd14, 5'd14), 5'd14, 32'h4);
        retire("chain_3", imm_op(fn_add, 5'd15, 5'd14, 12'h003), 5'd15, 32'h7);
        retire("gap_fill", imm_op(fn_add, 5'd16, 5'd0, 12'h009), 5'd16, 32'h9);
        retire("gap_use", reg_op(7'h00, fn_add, 5'd17, 5'd15, 5'd14), 5'd17, 32'hB);
        ////////////////////
        // Taken branches skip two words
        emit(branch_to(fn_beq, 5'd1, 5'd1, 13'd12));
        emit(imm_op(fn_add, 5'd20, 5'd0, 12'h001));
        emit(imm_op(fn_add, 5'd21, 5'd0, 12'h002));
        retire("beq_taken", imm_op(fn_add, 5'd18, 5'd0, 12'h011), 5'd18, 32'h11);
        emit(branch_to(fn_bne, 5'd1, 5'd2, 13'd12));
        emit(imm_op(fn_add, 5'd20, 5'd0, 12'h003));
        emit(imm_op(fn_add, 5'd21, 5'd0, 12'h004));
        retire("bne_taken", imm_op(fn_add, 5'd19, 5'd0, 12'h022), 5'd19, 32'h22);
        emit(branch_to(fn_blt, 5'd6, 5'd1, 13'd12));   // -7 < 5
        emit(imm_op(fn_add, 5'd22, 5'd0, 12'h005));
        emit(imm_op(fn_add, 5'd23, 5'd0, 12'h006));
        retire("blt_taken", imm_op(fn_add, 5'd20, 5'd0, 12'h033), 5'd20, 32'h33);
        emit(branch_to(fn_bge, 5'd1, 5'd6, 13'd12));
        emit(imm_op(fn_add, 5'd22, 5'd0, 12'h007));
        emit(imm_op(fn_add, 5'd23, 5'd0, 12'h008));
        retire("bge_taken", imm_op(fn_add, 5'd21, 5'd0, 12'h044), 5'd21, 32'h44);
        // Conditions that fail fall through
        emit(branch_to(fn_beq, 5'd1, 5'd2, 13'd12));
        retire("beq_fall", imm_op(fn_add, 5'd22, 5'd0, 12'h055), 5'd22, 32'h55);
        emit(branch_to(fn_bne, 5'd1, 5'd1, 13'd12));
        retire("bne_fall", imm_op(fn_add, 5'd23, 5'd0, 12'h066), 5'd23, 32'h66);
        emit(branch_to(fn_blt, 5'd1, 5'd6, 13'd12));
        retire("blt_fall", imm_op(fn_add, 5'd24, 5'd0, 12'h077), 5'd24, 32'h77);
        emit(branch_to(fn_bge, 5'd6, 5'd1, 13'd12));
        retire("bge_fall", imm_op(fn_add, 5'd25, 5'd0, 12'h088), 5'd25, 32'h88);
        // x0 write retires but must not stick
        retire("addi_x0", imm_op(fn_add, 5'd0, 5'd0, 12'h05A), 5'd0, 32'h5A);
        retire("read_x0", reg_op(7'h00, fn_add, 5'd26, 5'd0, 5'd1), 5'd26, 32'h5);
        emit(branch_to(fn_beq, 5'd0, 5'd0, 13'd0));     // Self loop
        // Shadow of the self loop, never retired
        emit(imm_op(fn_add, 5'd27, 5'd0, 12'h0AA));
        emit(imm_op(fn_add, 5'd28, 5'd0, 12'h0BB));
    endtask

    ////////////////////
    // Checks

    task automatic check_idle(input string name, input word_t addr);
        assert (!wb.valid)
        else
        begin
            mismatches++;
            $display("MISMATCH %s wb.valid expected 0 actual 1", name);
        end
        assert (instr_addr == addr)
        else
        begin
            mismatches++;
            $display("MISMATCH %s instr_addr expected %h actual %h", name, addr, instr_addr);
        end
    endtask

    task automatic wait_for_wb(output bit seen);
        seen = 1'b0;
        for (int i = 0; i < timeout && !seen; i++)
        begin
            @(negedge clk);
            seen = wb.valid;
        end
    endtask

    initial
    begin
        bit seen;
        mismatches = 0;
        timeouts   = 0;
        rst        = 1'b1;
        write_program();
        for (int i = 0; i < 4; i++)
        begin
            @(negedge clk);
            check_idle("reset", reset_pc);
        end
        @(posedge clk);
        rst <= 1'b0;
        // Fetch runs ahead while the pipe fills
        for (int i = 0; i < 4; i++)
        begin
            @(negedge clk);
            check_idle("after_reset", reset_pc + word_t'(4 * i));
        end
        for (int n = 0; n < exp_name.size(); n++)
        begin
            wait_for_wb(seen);
            if (!seen)
            begin
                timeouts++;
                $display("Timed out waiting for the writeback of %s", exp_name[n]);
                break;
            end
            assert (wb.rd == exp_rd[n])
            else
            begin
                mismatches++;
                $display("MISMATCH %s rd expected %0d actual %0d", exp_name[n], exp_rd[n], wb.rd);
            end
            assert (wb.data == exp_data[n])
            else
            begin
                mismatches++;
                $display("MISMATCH %s data expected %h actual %h", exp_name[n], exp_data[n],
                         wb.data);
            end
        end
        if (timeouts == 0)
        begin
            for (int i = 0; i < timeout; i++)
            begin
                @(negedge clk);
                assert (!wb.valid)
                else
                begin
                    mismatches++;
                    $display("MISMATCH program_end wb.valid expected 0 actual 1");
                end
            end
        end
        $display("Mismatches: %0d, timeouts: %0d", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

/* rv_core.f */
logic/rv_isa_pkg.sv
logic/rv_pipe_pkg.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_hazard.sv
logic/rv_core.sv
bench/rv_core_tb.sv

/* Makefile */
# Verilator build and regression for rv_core

VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= rv_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) 2>&1 | tee $(LOG)

check: run
	@if grep -qx '$(PASS_MSG)' $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
